/* verilog/gf_pkg.sv */
package gf_pkg;

	// window geometry, S = 2*alpha+1
	parameter int ALPHA = 1;
	parameter int WIN_S = 2 * ALPHA + 1;

	parameter int FRAME_ROWS = 10;
	parameter int FRAME_COLS = 12;
	parameter int ROW_BITS = $clog2(FRAME_ROWS);
	parameter int COL_BITS = $clog2(FRAME_COLS);

	parameter int EPS_TERM = 50; // regularisation on the variance numerator

	// running strip integrals over one line
	parameter int LSUM_W = 8 + $clog2(WIN_S * FRAME_COLS);
	parameter int LSUM2_W = 16 + $clog2(WIN_S * FRAME_COLS);

	// square window sums
	parameter int WSUM_W = 8 + $clog2(WIN_S * WIN_S);
	parameter int WSUM2_W = 16 + $clog2(WIN_S * WIN_S);
	parameter int NUM_W = 2 * WSUM2_W + 2;

	typedef logic [7:0] pix_t;
	typedef logic [15:0] prod_t;
	typedef logic [ROW_BITS-1:0] row_t;
	typedef logic [COL_BITS-1:0] col_t;
	typedef logic [LSUM_W-1:0] lsum_t;
	typedef logic [LSUM2_W-1:0] lsum2_t;
	typedef logic [WSUM_W-1:0] wsum_t;
	typedef logic [WSUM2_W-1:0] wsum2_t;
	typedef logic signed [NUM_W-1:0] num_t;

endpackage

/* verilog/pixel_product_stage.sv */
`timescale 1ns/1ns
module pixel_product_stage
	import gf_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  in_valid,
	input  pix_t  pix_i,
	input  pix_t  pix_p,
	input  pix_t  old_i,
	input  pix_t  old_p,
	output logic  prod_valid,
	output pix_t  new_i,
	output pix_t  new_p,
	output pix_t  gone_i,
	output pix_t  gone_p,
	output prod_t new_ii,
	output prod_t new_ip,
	output prod_t gone_ii,
	output prod_t gone_ip
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			prod_valid <= 1'b0;
		else
			prod_valid <= in_valid;
	end

	// pixels and products line up with prod_valid
	always_ff @(posedge clk) begin
		new_i <= pix_i;
		new_p <= pix_p;
		gone_i <= old_i; // row r-S, leaves the strip
		gone_p <= old_p;
		new_ii <= pix_i * pix_i;
		new_ip <= pix_i * pix_p;
		gone_ii <= old_i * old_i;
		gone_ip <= old_i * old_p;
	end

endmodule

/* verilog/banked_line_buffer.sv */
`timescale 1ns/1ns
module banked_line_buffer
	import gf_pkg::*;
#(
	parameter int DATA_W = LSUM_W
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wen,
	input  col_t              waddr,
	input  col_t              raddr_a,
	input  col_t              raddr_b,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata_a,
	output logic [DATA_W-1:0] rdata_b
);

	localparam int BANK_WORDS = (FRAME_COLS + 1) / 2;

	// bank 0 holds even columns, bank 1 odd columns
	logic [DATA_W-1:0] bank_mem [2][BANK_WORDS];
	logic [DATA_W-1:0] bank_q [2];
	logic [COL_BITS-2:0] bank_raddr [2];
	logic a_odd_q; // parity of the read address a, aligned with bank_q

	// the two read columns differ by an odd amount, so each bank serves exactly one port
	always_comb begin
		for (int b = 0; b < 2; b++) begin
			if (raddr_a[0] == b[0])
				bank_raddr[b] = raddr_a[COL_BITS-1:1];
			else
				bank_raddr[b] = raddr_b[COL_BITS-1:1];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < 2; b++) begin
				for (int w = 0; w < BANK_WORDS; w++)
					bank_mem[b][w] <= '0;
				bank_q[b] <= '0;
			end
			a_odd_q <= 1'b0;
		end else begin
			if (wen)
				bank_mem[waddr[0]][waddr[COL_BITS-1:1]] <= wdata;
			for (int b = 0; b < 2; b++)
				bank_q[b] <= bank_mem[b][bank_raddr[b]];
			a_odd_q <= raddr_a[0];
		end
	end

	// steer bank outputs back to the requesting ports
	assign rdata_a = a_odd_q ? bank_q[1] : bank_q[0];
	assign rdata_b = a_odd_q ? bank_q[0] : bank_q[1];

endmodule

/* verilog/box_sum_engine.sv */
`timescale 1ns/1ns
module box_sum_engine
	import gf_pkg::*;
#(
	parameter int DATA_W = 8,
	parameter int LINE_W = LSUM_W
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  in_valid,
	input  logic [DATA_W-1:0]                     add_val, // newest row
	input  logic [DATA_W-1:0]                     sub_val, // row r-S
	input  logic [LINE_W-1:0]                     line_rd_a,
	input  logic [LINE_W-1:0]                     line_rd_b,
	output logic                                  line_wen,
	output col_t                                  line_waddr,
	output col_t                                  line_raddr_a,
	output col_t                                  line_raddr_b,
	output logic [LINE_W-1:0]                     line_wdata,
	output logic [DATA_W+$clog2(WIN_S*WIN_S)-1:0] win_sum,
	output logic                                  win_valid
);

	localparam int SUM_W = DATA_W + $clog2(WIN_S * WIN_S);

	row_t row;
	col_t col, col_nxt, rd_col;
	logic last_col;
	logic full_win;
	logic [1:0] full_pipe;

	logic [LINE_W-1:0] ii_cur; // strip integral of the previous beat
	logic [LINE_W-1:0] above_prev; // line above at the previous column
	logic [LINE_W-1:0] left_q, diff_q;
	logic [LINE_W-1:0] ii_next, left_term, up_term, up_left_term, left_val;
	logic [DATA_W-1:0] gone_val;

	assign last_col = (col == col_t'(FRAME_COLS - 1));
	assign col_nxt = last_col ? '0 : col + 1'b1;

	// prefetch the columns of the next beat
	assign rd_col = in_valid ? col_nxt : col;
	assign line_raddr_a = rd_col;
	// keep port b in range when c-S is negative, data is masked anyway
	assign line_raddr_b = (rd_col >= col_t'(WIN_S)) ? rd_col - col_t'(WIN_S)
		: rd_col + col_t'(WIN_S);

	// frame edge masks
	assign left_term = (col == '0) ? '0 : ii_cur;
	assign up_term = (row == '0) ? '0 : line_rd_a;
	assign up_left_term = (row == '0 || col == '0) ? '0 : above_prev;
	assign gone_val = (row < WIN_S) ? '0 : sub_val;
	assign left_val = (col < WIN_S) ? '0 : line_rd_b;

	assign ii_next = left_term + up_term - up_left_term + add_val - gone_val;

	assign line_wen = in_valid;
	assign line_waddr = col;
	assign line_wdata = ii_next;

	assign full_win = in_valid && row >= WIN_S - 1 && col >= WIN_S - 1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row <= '0;
			col <= '0;
			full_pipe <= 2'b00;
			win_valid <= 1'b0;
		end else begin
			if (in_valid) begin
				col <= col_nxt;
				if (last_col)
					row <= (row == row_t'(FRAME_ROWS - 1)) ? '0 : row + 1'b1;
			end
			full_pipe <= {full_pipe[0], full_win};
			win_valid <= full_pipe[1];
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			ii_cur <= ii_next;
			above_prev <= line_rd_a;
			left_q <= left_val; // strip integral at c-S, same row
		end
		diff_q <= ii_cur - left_q;
		win_sum <= SUM_W'(diff_q); // true sum fits, upper bits drop
	end

endmodule

/* verilog/moment_numerator.sv */
`timescale 1ns/1ns
module moment_numerator
	import gf_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   win_valid,
	input  wsum_t  sum_i,
	input  wsum_t  sum_p,
	input  wsum2_t sum_ii,
	input  wsum2_t sum_ip,
	output logic   out_valid,
	output wsum_t  out_sum_i,
	output wsum_t  out_sum_p,
	output num_t   var_num,
	output num_t   cov_num
);

	localparam num_t AREA = num_t'(WIN_S * WIN_S); // full windows only

	num_t ext_i, ext_p, ext_ii, ext_ip;
	num_t var_nxt, cov_nxt;

	// zero-extend into the signed numerator width
	assign ext_i = num_t'(sum_i);
	assign ext_p = num_t'(sum_p);
	assign ext_ii = num_t'(sum_ii);
	assign ext_ip = num_t'(sum_ip);

	assign var_nxt = AREA * ext_ii - ext_i * ext_i + num_t'(EPS_TERM);
	assign cov_nxt = AREA * ext_ip - ext_i * ext_p;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= win_valid;
	end

	always_ff @(posedge clk) begin
		out_sum_i <= sum_i;
		out_sum_p <= sum_p;
		var_num <= var_nxt;
		cov_num <= cov_nxt;
	end

endmodule

/* verilog/guided_stats_top.sv */
`timescale 1ns/1ns
module guided_stats_top
	import gf_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  in_valid,
	input  pix_t  pix_i,
	input  pix_t  pix_p,
	input  pix_t  old_i,
	input  pix_t  old_p,
	output logic  out_valid,
	output wsum_t sum_i,
	output wsum_t sum_p,
	output num_t  var_num,
	output num_t  cov_num
);

	logic prod_valid, win_valid;
	pix_t new_i, new_p, gone_i, gone_p;
	prod_t new_ii, new_ip, gone_ii, gone_ip;
	wsum_t win_i, win_p;
	wsum2_t win_ii, win_ip;

	// one line buffer per engine
	logic i_wen, p_wen, ii_wen, ip_wen;
	col_t i_waddr, i_raddr_a, i_raddr_b;
	col_t p_waddr, p_raddr_a, p_raddr_b;
	col_t ii_waddr, ii_raddr_a, ii_raddr_b;
	col_t ip_waddr, ip_raddr_a, ip_raddr_b;
	lsum_t i_wdata, i_rd_a, i_rd_b;
	lsum_t p_wdata, p_rd_a, p_rd_b;
	lsum2_t ii_wdata, ii_rd_a, ii_rd_b;
	lsum2_t ip_wdata, ip_rd_a, ip_rd_b;

	pixel_product_stage product_stage (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.pix_i(pix_i), .pix_p(pix_p), .old_i(old_i), .old_p(old_p),
		.prod_valid(prod_valid), .new_i(new_i), .new_p(new_p), .gone_i(gone_i), .gone_p(gone_p),
		.new_ii(new_ii), .new_ip(new_ip), .gone_ii(gone_ii), .gone_ip(gone_ip)
	);

	// engine_i sets the output schedule, the others run in lockstep
	box_sum_engine #(.DATA_W($bits(pix_t)), .LINE_W($bits(lsum_t))) engine_i (
		.clk(clk), .rst_n(rst_n), .in_valid(prod_valid), .add_val(new_i), .sub_val(gone_i),
		.line_rd_a(i_rd_a), .line_rd_b(i_rd_b), .line_wen(i_wen), .line_waddr(i_waddr),
		.line_raddr_a(i_raddr_a), .line_raddr_b(i_raddr_b), .line_wdata(i_wdata),
		.win_sum(win_i), .win_valid(win_valid)
	);

	box_sum_engine #(.DATA_W($bits(pix_t)), .LINE_W($bits(lsum_t))) engine_p (
		.clk(clk), .rst_n(rst_n), .in_valid(prod_valid), .add_val(new_p), .sub_val(gone_p),
		.line_rd_a(p_rd_a), .line_rd_b(p_rd_b), .line_wen(p_wen), .line_waddr(p_waddr),
		.line_raddr_a(p_raddr_a), .line_raddr_b(p_raddr_b), .line_wdata(p_wdata),
		.win_sum(win_p), .win_valid()
	);

	box_sum_engine #(.DATA_W($bits(prod_t)), .LINE_W($bits(lsum2_t))) engine_ii (
		.clk(clk), .rst_n(rst_n), .in_valid(prod_valid), .add_val(new_ii), .sub_val(gone_ii),
		.line_rd_a(ii_rd_a), .line_rd_b(ii_rd_b), .line_wen(ii_wen), .line_waddr(ii_waddr),
		.line_raddr_a(ii_raddr_a), .line_raddr_b(ii_raddr_b), .line_wdata(ii_wdata),
		.win_sum(win_ii), .win_valid()
	);

	box_sum_engine #(.DATA_W($bits(prod_t)), .LINE_W($bits(lsum2_t))) engine_ip (
		.clk(clk), .rst_n(rst_n), .in_valid(prod_valid), .add_val(new_ip), .sub_val(gone_ip),
		.line_rd_a(ip_rd_a), .line_rd_b(ip_rd_b), .line_wen(ip_wen), .line_waddr(ip_waddr),
		.line_raddr_a(ip_raddr_a), .line_raddr_b(ip_raddr_b), .line_wdata(ip_wdata),
		.win_sum(win_ip), .win_valid()
	);

	banked_line_buffer #(.DATA_W($bits(lsum_t))) line_i (
		.clk(clk), .rst_n(rst_n), .wen(i_wen), .waddr(i_waddr), .raddr_a(i_raddr_a),
		.raddr_b(i_raddr_b), .wdata(i_wdata), .rdata_a(i_rd_a), .rdata_b(i_rd_b)
	);

	banked_line_buffer #(.DATA_W($bits(lsum_t))) line_p (
		.clk(clk), .rst_n(rst_n), .wen(p_wen), .waddr(p_waddr), .raddr_a(p_raddr_a),
		.raddr_b(p_raddr_b), .wdata(p_wdata), .rdata_a(p_rd_a), .rdata_b(p_rd_b)
	);

	banked_line_buffer #(.DATA_W($bits(lsum2_t))) line_ii (
		.clk(clk), .rst_n(rst_n), .wen(ii_wen), .waddr(ii_waddr), .raddr_a(ii_raddr_a),
		.raddr_b(ii_raddr_b), .wdata(ii_wdata), .rdata_a(ii_rd_a), .rdata_b(ii_rd_b)
	);

	banked_line_buffer #(.DATA_W($bits(lsum2_t))) line_ip (
		.clk(clk), .rst_n(rst_n), .wen(ip_wen), .waddr(ip_waddr), .raddr_a(ip_raddr_a),
		.raddr_b(ip_raddr_b), .wdata(ip_wdata), .rdata_a(ip_rd_a), .rdata_b(ip_rd_b)
	);

	moment_numerator numerator (
		.clk(clk), .rst_n(rst_n), .win_valid(win_valid),
		.sum_i(win_i), .sum_p(win_p), .sum_ii(win_ii), .sum_ip(win_ip),
		.out_valid(out_valid), .out_sum_i(sum_i), .out_sum_p(sum_p),
		.var_num(var_num), .cov_num(cov_num)
	);

endmodule

/* include/tb_check.svh */
`ifndef TB_CHECK_SVH
`define TB_CHECK_SVH

// compare one DUT value against the model value
task automatic check_value(input string name, input longint actual, input longint expected);
	if (actual !== expected) begin
		$display("error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
		abort_run("a DUT output did not match the reference model");
	end
endtask

// run until every queued output beat has been seen, bounded by max_cycles
task automatic drain_outputs(input int max_cycles);
	int waited;
	waited = 0;
	while (exp_cyc.size() != 0) begin
		if (waited >= max_cycles) begin
			abort_run($sformatf("timeout, %0d expected outputs never came", exp_cyc.size()));
		end else begin
			next_cycle();
			waited++;
		end
	end
	repeat (LATENCY + 2)
		next_cycle(); // room for stray beats to show up
endtask

`endif

/* test/tb_guided_stats.sv */
`timescale 1ns/1ns
module tb_guided_stats
	import gf_pkg::*;
();

	localparam int SEED = 32'h50428d9d;
	localparam int LATENCY = 5; // in_valid beat to out_valid

	logic clk;
	logic rst_n;
	logic in_valid;
	pix_t pix_i, pix_p, old_i, old_p;
	logic out_valid;
	wsum_t sum_i, sum_p;
	num_t var_num, cov_num;

	int img_i [FRAME_ROWS][FRAME_COLS];
	int img_p [FRAME_ROWS][FRAME_COLS];
	int cyc = 0;
	int flat_level; // -1 for random images

	// expected beats in arrival order
	longint exp_si[$], exp_sp[$], exp_var[$], exp_cov[$];
	int exp_cyc[$];

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	`include "tb_check.svh"

	guided_stats_top guided_stats_top_inst (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.pix_i(pix_i), .pix_p(pix_p), .old_i(old_i), .old_p(old_p),
		.out_valid(out_valid), .sum_i(sum_i), .sum_p(sum_p),
		.var_num(var_num), .cov_num(cov_num)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			if (exp_cyc.size() == 0) begin
				abort_run("out_valid rose with no output expected");
			end else begin
				check_value("out_valid cycle", cyc, exp_cyc.pop_front());
				check_value("sum_i", longint'(sum_i), exp_si.pop_front());
				check_value("sum_p", longint'(sum_p), exp_sp.pop_front());
				check_value("var_num", longint'(var_num), exp_var.pop_front());
				check_value("cov_num", longint'(cov_num), exp_cov.pop_front());
				if (flat_level >= 0) begin // flat image has zero variance
					check_value("sum_i", longint'(sum_i), flat_level * WIN_S * WIN_S);
					check_value("sum_p", longint'(sum_p), flat_level * WIN_S * WIN_S);
					check_value("var_num", longint'(var_num), EPS_TERM);
					check_value("cov_num", longint'(cov_num), 0);
				end
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic fill_random();
		for (int r = 0; r < FRAME_ROWS; r++)
			for (int c = 0; c < FRAME_COLS; c++) begin
				img_i[r][c] = int'($urandom_range(255, 0));
				img_p[r][c] = int'($urandom_range(255, 0));
			end
	endtask

	// window sums over rows r-S+1..r and columns c-S+1..c
	task automatic push_expected(input int r, input int c);
		longint si = 0;
		longint sp = 0;
		longint sii = 0;
		longint sip = 0;
		for (int y = r - WIN_S + 1; y <= r; y++)
			for (int x = c - WIN_S + 1; x <= c; x++) begin
				si += img_i[y][x];
				sp += img_p[y][x];
				sii += img_i[y][x] * img_i[y][x];
				sip += img_i[y][x] * img_p[y][x];
			end
		exp_si.push_back(si);
		exp_sp.push_back(sp);
		exp_var.push_back(WIN_S * WIN_S * sii - si * si + EPS_TERM);
		exp_cov.push_back(WIN_S * WIN_S * sip - si * sp);
		exp_cyc.push_back(cyc + LATENCY);
	endtask

	task automatic send_frame(input bit gaps);
		for (int r = 0; r < FRAME_ROWS; r++)
			for (int c = 0; c < FRAME_COLS; c++) begin
				pix_i = pix_t'(img_i[r][c]);
				pix_p = pix_t'(img_p[r][c]);
				if (r >= WIN_S) begin
					old_i = pix_t'(img_i[r - WIN_S][c]);
					old_p = pix_t'(img_p[r - WIN_S][c]);
				end else begin
					old_i = pix_t'($urandom); // junk that the DUT must ignore
					old_p = pix_t'($urandom);
				end
				in_valid = 1'b1;
				if (r >= WIN_S - 1 && c >= WIN_S - 1)
					push_expected(r, c);
				next_cycle();
				in_valid = 1'b0;
				if (gaps)
					repeat ($urandom_range(3, 1))
						next_cycle();
			end
	endtask

	task automatic test_idle_after_reset();
		repeat (20) begin
			@(negedge clk);
			check_value("out_valid", longint'(out_valid), 0);
		end
		next_cycle();
	endtask

	task automatic test_constant_image();
		for (int r = 0; r < FRAME_ROWS; r++)
			for (int c = 0; c < FRAME_COLS; c++) begin
				img_i[r][c] = 7;
				img_p[r][c] = 7;
			end
		flat_level = 7;
		send_frame(1'b0);
		drain_outputs(40);
		flat_level = -1;
	endtask

	task automatic test_random_frame(input bit gaps);
		fill_random();
		send_frame(gaps);
		drain_outputs(40);
	endtask

	// second frame starts while the first is still in flight
	task automatic test_two_frames();
		fill_random();
		send_frame(1'b0);
		fill_random();
		send_frame(1'b0);
		drain_outputs(40);
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		in_valid = 1'b0;
		pix_i = '0;
		pix_p = '0;
		old_i = '0;
		old_p = '0;
		flat_level = -1;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_idle_after_reset();
		test_constant_image();
		test_random_frame(1'b0);
		test_random_frame(1'b1);
		test_two_frames();
		if (exp_cyc.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("%0d expected outputs are still pending", exp_cyc.size());
			$display("Errors found");
			$fatal(1, "outputs missing at the end of the run");
		end
	end

endmodule

/* sim.f */
+incdir+include
verilog/gf_pkg.sv
verilog/pixel_product_stage.sv
verilog/banked_line_buffer.sv
verilog/box_sum_engine.sv
verilog/moment_numerator.sv
verilog/guided_stats_top.sv
test/tb_guided_stats.sv

/* run_sim.sh */
#!/bin/sh
# build and run the guided filter statistics testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f sim.f \
	--top-module tb_guided_stats -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_guided_stats)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
	exit 0
fi
echo "pass message not found"
exit 1
